// File: datapath_macros.svh
`ifndef DATAPATH_MACROS_SVH
`define DATAPATH_MACROS_SVH

`define WordWidth 32

// Enable vector, one bit per loadable register
`define EnR0      0   // R0..R15 sit at EnR0 + n
`define EnHi      16
`define EnLo      17
`define EnPc      20
`define EnMdr     21
`define EnOutPort 22
`define EnIr      23
`define EnZ       24
`define EnMar     25
`define EnY       27

// busSelect vector, one bit per bus source
`define SelR0     0   // R0..R15 sit at SelR0 + n
`define SelHi     16
`define SelLo     17
`define SelZLo    18
`define SelZHi    19
`define SelPc     20
`define SelMdr    21
`define SelInPort 22
`define SelCSign  23

// ALU operation codes
`define OpAdd  4'd0
`define OpSub  4'd1
`define OpAnd  4'd2
`define OpOr   4'd3
`define OpShr  4'd4
`define OpShl  4'd5
`define OpRor  4'd6
`define OpRol  4'd7
`define OpMul  4'd8
`define OpDiv  4'd9
`define OpNeg  4'd10
`define OpNot  4'd11
`define OpShra 4'd13  // Kept at 13 to match existing programs

`endif

// File: datapathPkg.sv
`default_nettype none

package datapathPkg;

  // Register-to-register layout
  typedef struct packed {
    logic [4:0]  opcode;
    logic [3:0]  ra;
    logic [3:0]  rb;
    logic [3:0]  rc;
    logic [14:0] unused;
  } rFormatT;

  // Immediate layout, constant is sign-extended on the bus
  typedef struct packed {
    logic [4:0]  opcode;
    logic [3:0]  ra;
    logic [3:0]  rb;
    logic [18:0] constant;
  } iFormatT;

  // Same IR word, read either way
  typedef union packed {
    rFormatT rFormat;
    iFormatT iFormat;
  } instrWord;

endpackage

`default_nettype wire

// File: busIf.sv
`timescale 1ns/1ps
`default_nettype none

interface busIf;
  logic [31:0] busValue;   // Shared bus
  logic [31:0] enable;     // One-hot load strobes
  logic [31:0] busSelect;  // One-hot source selects
  logic        Clock;
  logic        rst;

  // Bus source side
  modport driver (
    output busValue,
    input  enable, busSelect, Clock, rst
  );

  // Register banks only listen
  modport regSide (
    input busValue, enable, busSelect, Clock, rst
  );
endinterface

`default_nettype wire

// File: registerFile.sv
`timescale 1ns/1ps
`default_nettype none
`include "datapath_macros.svh"

module registerFile import datapathPkg::*; (
  busIf.regSide       bus,
  input  logic        gra,
  input  logic        grb,
  input  logic        grc,
  input  logic        rIn,
  input  logic        rOut,
  input  instrWord    irWord,
  output logic [`WordWidth-1:0] regOut,
  output logic        regDrive
);

  logic [`WordWidth-1:0] regs [16];
  logic [3:0]            selIndex;   // Register named by the IR field
  logic                  directHit;

  // Select-and-encode, gra has priority over grb and grc
  always_comb begin
    selIndex = 4'd0;
    if (gra)      selIndex = irWord.rFormat.ra;
    else if (grb) selIndex = irWord.rFormat.rb;
    else if (grc) selIndex = irWord.rFormat.rc;
  end

  always_ff @(posedge bus.Clock) begin
    for (int i = 0; i < 16; i++) begin
      if (bus.rst) begin
        regs[i] <= '0;
      end else if (bus.enable[`EnR0 + i] || (rIn && selIndex == 4'(i))) begin
        regs[i] <= bus.busValue;
      end
    end
  end

  // Direct select bits first, lowest index wins
  always_comb begin
    directHit = 1'b0;
    regOut    = '0;
    for (int i = 15; i >= 0; i--) begin
      if (bus.busSelect[`SelR0 + i]) begin
        regOut    = regs[i];
        directHit = 1'b1;
      end
    end
    if (!directHit && rOut) regOut = regs[selIndex];  // Encoded read
  end

  assign regDrive = directHit | rOut;

endmodule

`default_nettype wire

// File: specialRegisters.sv
`timescale 1ns/1ps
`default_nettype none
`include "datapath_macros.svh"

module specialRegisters import datapathPkg::*; (
  busIf.regSide                 bus,
  input  logic [`WordWidth-1:0] MDataIn,
  input  logic                  mdRead,
  input  logic [`WordWidth-1:0] inPort,
  input  logic [63:0]           result,
  output logic [`WordWidth-1:0] yValue,
  output logic [`WordWidth-1:0] pcValue,
  output logic [`WordWidth-1:0] mdrValue,
  output logic [`WordWidth-1:0] hiValue,
  output logic [`WordWidth-1:0] loValue,
  output logic [`WordWidth-1:0] inPortValue,
  output logic [63:0]           zValue,
  output instrWord              irWord,
  output logic [`WordWidth-1:0] memAddress,
  output logic [`WordWidth-1:0] outPort
);

  // Program flow and memory side
  always_ff @(posedge bus.Clock) begin
    if (bus.rst) begin
      pcValue    <= '0;
      irWord     <= '0;
      memAddress <= '0;
      mdrValue   <= '0;
    end else begin
      if (bus.enable[`EnPc])  pcValue    <= bus.busValue;
      if (bus.enable[`EnIr])  irWord     <= bus.busValue;
      if (bus.enable[`EnMar]) memAddress <= bus.busValue;  // MAR drives memory address
      if (bus.enable[`EnMdr]) begin
        mdrValue <= mdRead ? MDataIn : bus.busValue;     // Memory read or bus write
      end
    end
  end

  // ALU operand and result registers
  always_ff @(posedge bus.Clock) begin
    if (bus.rst) begin
      yValue  <= '0;
      zValue  <= '0;
      hiValue <= '0;
      loValue <= '0;
    end else begin
      if (bus.enable[`EnY]) yValue  <= bus.busValue;
      if (bus.enable[`EnZ]) zValue  <= result;       // Full 64 bits for MUL and DIV
      if (bus.enable[`EnHi]) hiValue <= bus.busValue;
      if (bus.enable[`EnLo]) loValue <= bus.busValue;
    end
  end

  // I/O ports
  always_ff @(posedge bus.Clock) begin
    if (bus.rst) begin
      inPortValue <= '0;
      outPort     <= '0;
    end else begin
      inPortValue <= inPort;  // Free running sample
      if (bus.enable[`EnOutPort]) begin
        outPort <= bus.busValue;
      end
    end
  end

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "datapath_macros.svh"

module alu (
  input  logic [`WordWidth-1:0] yValue,   // Operand A
  input  logic [`WordWidth-1:0] busValue, // Operand B
  input  logic [3:0]            controlSignals,
  input  logic                  incPc,
  output logic [63:0]           result
);

  logic [4:0]         shAmt;
  logic [63:0]        aWide;
  logic [63:0]        bWide;
  logic [63:0]        product;
  logic signed [31:0] divisor;
  logic signed [31:0] quotient;
  logic signed [31:0] remainder;
  logic signed [31:0] yShra;

  assign shAmt = busValue[4:0];

  // Sign-extend before multiplying so the low 64 bits are the signed product
  assign aWide   = {{32{yValue[31]}}, yValue};
  assign bWide   = {{32{busValue[31]}}, busValue};
  assign product = aWide * bWide;

  assign divisor   = (busValue == '0) ? 32'sd1 : $signed(busValue);  // Avoid x on zero
  assign quotient  = $signed(yValue) / divisor;
  assign remainder = $signed(yValue) % divisor;

  assign yShra = $signed(yValue) >>> shAmt;

  always_comb begin
    result = '0;
    if (incPc) begin
      result[31:0] = busValue + 32'd1;  // PC increment path
    end else begin
      case (controlSignals)
        `OpAdd:  result[31:0] = yValue + busValue;
        `OpSub:  result[31:0] = yValue - busValue;
        `OpAnd:  result[31:0] = yValue & busValue;
        `OpOr:   result[31:0] = yValue | busValue;
        `OpShr:  result[31:0] = yValue >> shAmt;
        `OpShl:  result[31:0] = yValue << shAmt;
        `OpShra: result[31:0] = yShra;
        `OpRor:  result[31:0] = (yValue >> shAmt) | (yValue << (6'd32 - {1'b0, shAmt}));
        `OpRol:  result[31:0] = (yValue << shAmt) | (yValue >> (6'd32 - {1'b0, shAmt}));
        `OpMul:  result = product;
        `OpDiv:  begin
          if (busValue != '0) result = {remainder, quotient};  // HI gets remainder
        end
        `OpNeg:  result[31:0] = -busValue;
        `OpNot:  result[31:0] = ~busValue;
        default: result = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: busMux.sv
`timescale 1ns/1ps
`default_nettype none
`include "datapath_macros.svh"

module busMux import datapathPkg::*; (
  busIf.driver                  bus,
  input  logic [`WordWidth-1:0] regOut,
  input  logic                  regDrive,
  input  logic [`WordWidth-1:0] pcValue,
  input  logic [`WordWidth-1:0] mdrValue,
  input  logic [`WordWidth-1:0] hiValue,
  input  logic [`WordWidth-1:0] loValue,
  input  logic [`WordWidth-1:0] inPortValue,
  input  logic [63:0]           zValue,
  input  instrWord              irWord
);

  logic [4:0]            source;  // Encoded source index
  logic [`WordWidth-1:0] cSign;

  // Immediate from the I-format view
  assign cSign = {{13{irWord.iFormat.constant[18]}}, irWord.iFormat.constant};

  // 32-to-5 priority encoder over the special sources, lowest bit wins
  always_comb begin
    source = 5'd0;
    for (int i = 31; i >= 16; i--) begin
      if (bus.busSelect[i]) source = 5'(i);
    end
  end

  // Register sources sit below all others, so they go first
  always_comb begin
    bus.busValue = '0;
    if (regDrive) begin
      bus.busValue = regOut;
    end else begin
      case (source)
        `SelHi:     bus.busValue = hiValue;
        `SelLo:     bus.busValue = loValue;
        `SelZLo:    bus.busValue = zValue[31:0];
        `SelZHi:    bus.busValue = zValue[63:32];
        `SelPc:     bus.busValue = pcValue;
        `SelMdr:    bus.busValue = mdrValue;
        `SelInPort: bus.busValue = inPortValue;
        `SelCSign:  bus.busValue = cSign;
        default:    bus.busValue = '0;  // Nothing selected
      endcase
    end
  end

endmodule

`default_nettype wire

// File: dataPath.sv
`timescale 1ns/1ps
`default_nettype none

module dataPath import datapathPkg::*; (
  input  logic        Clock,
  input  logic        rst,
  input  logic [31:0] enable,
  input  logic [31:0] busSelect,
  input  logic [31:0] inPort,
  input  logic [31:0] MDataIn,
  input  logic        mdRead,
  input  logic [3:0]  controlSignals,
  input  logic        incPc,
  input  logic        gra,
  input  logic        grb,
  input  logic        grc,
  input  logic        rIn,
  input  logic        rOut,
  output logic [31:0] busMuxOut,
  output logic [31:0] memAddress,
  output logic [31:0] outPort
);

  busIf bus ();

  logic [31:0] regOut;
  logic        regDrive;
  logic [31:0] yValue;
  logic [31:0] pcValue;
  logic [31:0] mdrValue;
  logic [31:0] hiValue;
  logic [31:0] loValue;
  logic [31:0] inPortValue;
  logic [63:0] zValue;
  logic [63:0] result;
  instrWord    irWord;

  // Control comes in on plain ports
  assign bus.Clock     = Clock;
  assign bus.rst       = rst;
  assign bus.enable    = enable;
  assign bus.busSelect = busSelect;
  assign busMuxOut     = bus.busValue;

  registerFile i_registerFile (
    .bus(bus), .gra(gra), .grb(grb), .grc(grc), .rIn(rIn), .rOut(rOut),
    .irWord(irWord), .regOut(regOut), .regDrive(regDrive)
  );

  specialRegisters i_specialRegisters (
    .bus(bus), .MDataIn(MDataIn), .mdRead(mdRead), .inPort(inPort), .result(result),
    .yValue(yValue), .pcValue(pcValue), .mdrValue(mdrValue), .hiValue(hiValue),
    .loValue(loValue), .inPortValue(inPortValue), .zValue(zValue), .irWord(irWord),
    .memAddress(memAddress), .outPort(outPort)
  );

  alu i_alu (
    .yValue(yValue), .busValue(bus.busValue), .controlSignals(controlSignals),
    .incPc(incPc), .result(result)
  );

  busMux i_busMux (
    .bus(bus), .regOut(regOut), .regDrive(regDrive), .pcValue(pcValue),
    .mdrValue(mdrValue), .hiValue(hiValue), .loValue(loValue),
    .inPortValue(inPortValue), .zValue(zValue), .irWord(irWord)
  );

endmodule

`default_nettype wire

// File: dataPathTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "datapath_macros.svh"

module dataPathTb;

  localparam int ResetCycles  = 16;
  localparam int ResetTimeout = 64;
  localparam logic [31:0] ShraWord = {5'd13, 4'd6, 4'd2, 4'd0, 15'h0123};  // rc field names R0
  localparam logic [31:0] ImmWord  = {5'd12, 4'd1, 4'd2, 19'h61a2b};       // Negative constant

  // One table row is one clock cycle
  typedef struct packed {
    logic [31:0] enable;
    logic [31:0] busSelect;
    logic        mdRead;
    logic [31:0] mDataIn;
    logic [31:0] inPort;
    logic [3:0]  ctrl;
    logic        incPc;
    logic        gra, grb, grc, rIn, rOut;
    logic        check;
    logic [31:0] expBus;
    logic        checkAddr;
    logic [31:0] expAddr;
    logic        checkOut;
    logic [31:0] expOut;
    logic        last;     // Closes a test
  } rowT;

  logic        Clock;
  logic        rst;
  logic [31:0] enable, busSelect, inPort, MDataIn;
  logic        mdRead;
  logic [3:0]  controlSignals;
  logic        incPc, gra, grb, grc, rIn, rOut;
  logic [31:0] busMuxOut, memAddress, outPort;

  rowT         rows[$];
  string       names[$];
  rowT         cur;        // Extra fields for the next pushed row
  logic [31:0] lfsrState;
  int          errors, passCount, failCount;
  logic        testBad;

  dataPath i_dataPath (.*);

  initial begin
    Clock = 1'b0;
    forever #2 Clock = ~Clock;
  end

  initial begin
    rst = 1'b1;
    repeat (ResetCycles) @(posedge Clock);
    #1 rst = 1'b0;
  end

  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [31:0] oneHot(input int idx);
    return 32'd1 << idx;
  endfunction

  function automatic logic [31:0] signExt19(input logic [18:0] c);
    if (c[18]) return {13'h1fff, c};
    return {13'h0000, c};
  endfunction

  // Expected Z for A = Y and B = bus
  function automatic logic [63:0] refAlu(input logic [3:0] op, input logic [31:0] a,
                                         input logic [31:0] b);
    logic [31:0] w;
    int          sa;
    int          sb;
    w  = '0;
    sa = a;
    sb = b;
    case (op)
      `OpAdd: w = a + b;
      `OpSub: w = a - b;
      `OpAnd: w = a & b;
      `OpOr:  w = a | b;
      `OpShra: begin
        w = a;
        repeat (b[4:0]) w = {w[31], w[31:1]};  // Sign bit refills from the top
      end
      `OpRol: begin
        w = a;
        repeat (b[4:0]) w = {w[30:0], w[31]};
      end
      `OpNeg: w = ~b + 32'd1;
      `OpNot: w = ~b;
      `OpMul: return longint'(sa) * longint'(sb);
      `OpDiv: begin
        if (sb == 0) return '0;
        return {sa % sb, sa / sb};  // Remainder high, quotient low
      end
      default: w = '0;
    endcase
    return {32'd0, w};
  endfunction

  task automatic pushRow(input string name, input logic [31:0] en, input logic [31:0] sel,
                         input logic [31:0] exp, input logic chk);
    cur.enable    = en;
    cur.busSelect = sel;
    cur.expBus    = exp;
    cur.check     = chk;
    rows.push_back(cur);
    names.push_back(name);
    cur = '0;
  endtask

  task automatic endTest();
    cur = rows[rows.size() - 1];
    cur.last = 1'b1;
    rows[rows.size() - 1] = cur;
    cur = '0;
  endtask

  // Memory read into MDR
  task automatic memRow(input string name, input logic [31:0] v);
    cur.mdRead  = 1'b1;
    cur.mDataIn = v;
    pushRow(name, oneHot(`EnMdr), '0, '0, 1'b0);
  endtask

  task automatic loadReg(input string name, input int idx, input logic [31:0] v);
    memRow(name, v);
    pushRow(name, oneHot(`EnR0 + idx), oneHot(`SelMdr), v, 1'b1);
  endtask

  // R2 -> Y, then R3 through the ALU into Z
  task automatic opRows(input string name, input logic [3:0] op, input logic [31:0] a,
                        input logic [31:0] b);
    loadReg(name, 2, a);
    loadReg(name, 3, b);
    pushRow(name, oneHot(`EnY), oneHot(`SelR0 + 2), a, 1'b1);
    cur.ctrl = op;
    pushRow(name, oneHot(`EnZ), oneHot(`SelR0 + 3), b, 1'b1);
  endtask

  task automatic aluTest(input string name, input logic [3:0] op, input logic [31:0] a,
                         input logic [31:0] b);
    logic [63:0] exp;
    exp = refAlu(op, a, b);
    opRows(name, op, a, b);
    pushRow(name, '0, oneHot(`SelZLo), exp[31:0], 1'b1);
    endTest();
  endtask

  task automatic mulDivTest(input string name, input logic [3:0] op, input logic [31:0] a,
                            input logic [31:0] b);
    logic [63:0] exp;
    exp = refAlu(op, a, b);
    opRows(name, op, a, b);
    pushRow(name, oneHot(`EnLo), oneHot(`SelZLo), exp[31:0], 1'b1);
    pushRow(name, oneHot(`EnHi), oneHot(`SelZHi), exp[63:32], 1'b1);
    pushRow(name, '0, oneHot(`SelLo), exp[31:0], 1'b1);
    pushRow(name, '0, oneHot(`SelHi), exp[63:32], 1'b1);
    endTest();
  endtask

  task automatic buildTable();
    logic [31:0] v;
    logic [31:0] pcInit;
    pushRow("reset", '0, '0, '0, 1'b1);
    pushRow("reset", '0, oneHot(`SelR0 + 5), '0, 1'b1);
    pushRow("reset", '0, oneHot(`SelPc), '0, 1'b1);
    endTest();
    v = randBits(32);
    loadReg("mdrLoad", 2, v);
    pushRow("mdrLoad", '0, oneHot(`SelR0 + 2), v, 1'b1);
    endTest();
    // R2 out to the output port register
    pushRow("outPort", oneHot(`EnOutPort), oneHot(`SelR0 + 2), v, 1'b1);
    cur.checkOut = 1'b1;
    cur.expOut   = v;
    pushRow("outPort", '0, '0, '0, 1'b1);
    endTest();
    v = randBits(32);
    cur.inPort = v;  // Sampled at the next edge
    pushRow("inPort", '0, '0, '0, 1'b0);
    pushRow("inPort", oneHot(`EnR0 + 4), oneHot(`SelInPort), v, 1'b1);
    pushRow("inPort", '0, oneHot(`SelR0 + 4), v, 1'b1);
    endTest();
    aluTest("shra", `OpShra, randBits(32) | 32'h8000_0000, randBits(5));
    aluTest("add", `OpAdd, randBits(32), randBits(32));
    aluTest("sub", `OpSub, randBits(32), randBits(32));
    aluTest("and", `OpAnd, randBits(32), randBits(32));
    aluTest("or", `OpOr, randBits(32), randBits(32));
    aluTest("rol", `OpRol, randBits(32), randBits(5));
    aluTest("neg", `OpNeg, randBits(32), randBits(32));
    aluTest("not", `OpNot, randBits(32), randBits(32));
    mulDivTest("mul", `OpMul, randBits(32), randBits(32));
    mulDivTest("div", `OpDiv, randBits(32), randBits(12) + 32'd1);
    // Fetch, PC + 1 through Z while MAR takes the old PC
    pcInit = randBits(16);
    loadReg("fetch", 0, pcInit);
    pushRow("fetch", oneHot(`EnPc), oneHot(`SelR0), pcInit, 1'b1);
    cur.incPc = 1'b1;
    pushRow("fetch", oneHot(`EnZ) | oneHot(`EnMar), oneHot(`SelPc), pcInit, 1'b1);
    cur.checkAddr = 1'b1;
    cur.expAddr   = pcInit;
    pushRow("fetch", oneHot(`EnPc), oneHot(`SelZLo), pcInit + 32'd1, 1'b1);
    pushRow("fetch", '0, oneHot(`SelPc), pcInit + 32'd1, 1'b1);
    memRow("fetch", ShraWord);
    pushRow("fetch", oneHot(`EnIr), oneHot(`SelMdr), ShraWord, 1'b1);
    endTest();
    // IR still holds the shra word
    v = randBits(32);
    memRow("selEncode", v);
    cur.grc = 1'b1;
    cur.rIn = 1'b1;
    pushRow("selEncode", '0, oneHot(`SelMdr), v, 1'b1);
    pushRow("selEncode", '0, oneHot(`SelR0), v, 1'b1);
    cur.grc  = 1'b1;
    cur.rOut = 1'b1;
    pushRow("selEncode", '0, '0, v, 1'b1);
    pushRow("selEncode", '0, oneHot(`SelCSign), signExt19(ShraWord[18:0]), 1'b1);
    memRow("selEncode", ImmWord);
    pushRow("selEncode", oneHot(`EnIr), oneHot(`SelMdr), ImmWord, 1'b1);
    pushRow("selEncode", '0, oneHot(`SelCSign), signExt19(ImmWord[18:0]), 1'b1);
    endTest();
  endtask

  task automatic applyRow(input rowT r);
    enable         = r.enable;
    busSelect      = r.busSelect;
    mdRead         = r.mdRead;
    MDataIn        = r.mDataIn;
    inPort         = r.inPort;
    controlSignals = r.ctrl;
    incPc          = r.incPc;
    gra            = r.gra;
    grb            = r.grb;
    grc            = r.grc;
    rIn            = r.rIn;
    rOut           = r.rOut;
  endtask

  initial begin : mainFlow
    rowT r;
    int  cycles;
    applyRow('0);
    lfsrState = 32'h0efb_76a2;
    errors    = 0;
    passCount = 0;
    failCount = 0;
    testBad   = 1'b0;
    cur       = '0;
    cycles    = 0;
    buildTable();
    while (rst !== 1'b0 && cycles < ResetTimeout) begin
      @(posedge Clock);
      cycles++;
    end
    if (rst !== 1'b0) begin
      $display("Reset was not released within %0d cycles", ResetTimeout);
      $display("Test FAILED");
      $finish;
    end else begin
      for (int k = 0; k < rows.size(); k++) begin
        r = rows[k];
        @(posedge Clock);
        #1;
        applyRow(r);
        #2;  // Bus has settled, next edge is 1 ns away
        if (r.check && busMuxOut !== r.expBus) begin
          $display("[ERROR] %s: busMuxOut expected %h, actual %h", names[k], r.expBus, busMuxOut);
          errors++;
          testBad = 1'b1;
        end
        if (r.checkAddr && memAddress !== r.expAddr) begin
          $display("[ERROR] %s: memAddress expected %h, actual %h", names[k], r.expAddr,
                   memAddress);
          errors++;
          testBad = 1'b1;
        end
        if (r.checkOut && outPort !== r.expOut) begin
          $display("[ERROR] %s: outPort expected %h, actual %h", names[k], r.expOut,
                   outPort);
          errors++;
          testBad = 1'b1;
        end
        if (r.last) begin
          if (testBad) begin
            failCount++;
            $display("%s: failed", names[k]);
          end else begin
            passCount++;
            $display("%s: passed", names[k]);
          end
          testBad = 1'b0;
        end
      end
      $display("Tests passed: %0d, failed: %0d, mismatches: %0d", passCount, failCount, errors);
      if (failCount == 0 && errors == 0) begin
        $display("Test OK");
      end else begin
        $display("Test FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
datapathPkg.sv
busIf.sv
registerFile.sv
specialRegisters.sv
alu.sv
busMux.sv
dataPath.sv
dataPathTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the datapath testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f files.f --top-module dataPathTb -o simDataPath; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/simDataPath)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
  exit 0
fi
exit 1
